// ==== tb.f ====
hdl/debug_pkg.sv
hdl/command_decoder.sv
hdl/dump_channel.sv
hdl/byte_serializer.sv
hdl/debug_unit.sv
bench/debug_unit_asserts.sv
bench/tb_debug_unit.sv

// ==== Bender.yml ====
package:
  name: debug_unit

sources:
  - hdl/debug_pkg.sv
  - hdl/command_decoder.sv
  - hdl/dump_channel.sv
  - hdl/byte_serializer.sv
  - hdl/debug_unit.sv
  - target: test
    files:
      - bench/debug_unit_asserts.sv
      - bench/tb_debug_unit.sv

// ==== bench/tb_debug_unit.sv ====
`timescale 1ns/100ps

module tb_debug_unit import debug_pkg::*; ();

    logic        i_clock = 1'b0;
    logic        i_reset;
    rx_byte_t    i_rx;
    logic        i_halt;
    logic        i_tx_done;
    word_t       i_pc_value;
    word_t       i_dmem_data;
    word_t       i_reg_data;
    tx_byte_t    o_tx;
    imem_write_t o_imem;
    logic        o_pipeline_enable;
    dump_req_t   o_dmem_req;
    dump_req_t   o_reg_req;

    word_t             dmem [2**ADDR_W];
    word_t             regs [2**ADDR_W];
    logic [ADDR_W-1:0] dmem_addr_q = '0;
    logic [ADDR_W-1:0] reg_addr_q = '0;
    int unsigned       tx_delay [256];   // uart back-pressure in cycles
    int unsigned       tx_count = 0;
    byte_t             tx_bytes [$];
    imem_write_t       writes [$];

    debug_unit dut0 (.*);

    always #5 i_clock = ~i_clock;

    // word sources take the address at the edge and answer before the next one
    always @(posedge i_clock) begin
        if (o_dmem_req.read) begin
            dmem_addr_q <= o_dmem_req.addr;
        end
        if (o_reg_req.read) begin
            reg_addr_q <= o_reg_req.addr;
        end
    end

    always @(negedge i_clock) begin
        i_dmem_data <= dmem[dmem_addr_q];
        i_reg_data  <= regs[reg_addr_q];
    end

    // uart transmitter
    always begin
        @(negedge i_clock);
        i_tx_done = 1'b0;
        if (o_tx.start) begin
            repeat (tx_delay[tx_count % 256]) @(negedge i_clock);
            tx_bytes.push_back(o_tx.data);
            tx_count++;
            i_tx_done = 1'b1;
        end
    end

    always @(negedge i_clock) begin
        if (o_imem.write) begin
            writes.push_back(o_imem);
        end
    end

    always @(dut0.u_asserts.error_count) begin
        if (dut0.u_asserts.error_count != 0) begin
            fail_run("An assertion in the bound checker failed");
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input word_t expected, input word_t actual, input string what);
        if (expected !== actual) begin
            fail_run($sformatf("Mismatch at %0t ns: %s, expected %h, got %h",
                               $time, what, expected, actual));
        end
    endtask

    task automatic send_byte(input byte_t value);
        i_rx.data = value;
        i_rx.done = 1'b1;
        @(negedge i_clock);
        i_rx.done = 1'b0;
    endtask

    task automatic reset_quiet();
        for (int n = 0; n < 32; n++) begin
            @(negedge i_clock);
            check(0, o_pipeline_enable, "pipeline enable while idle");
            check(0, o_tx.start, "tx start while idle");
            check(0, o_imem.write, "imem write while idle");
            check(0, o_dmem_req.read, "dmem read while idle");
            check(0, o_reg_req.read, "reg read while idle");
        end
    endtask

    // pc then data memory then registers with each word msb first
    task automatic expect_dump();
        byte_t expected [$];
        word_t word;
        int    n;
        for (int w = 0; w < 1 + 2 * 2**ADDR_W; w++) begin
            if (w == 0) begin
                word = i_pc_value;
            end else if (w <= 2**ADDR_W) begin
                word = dmem[w-1];
            end else begin
                word = regs[w-1-2**ADDR_W];
            end
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                expected.push_back(word[WORD_W-1-b*BYTE_W -: BYTE_W]);
            end
        end
        for (n = 0; n < 20000 && tx_bytes.size() < expected.size(); n++) begin
            @(negedge i_clock);
        end
        if (tx_bytes.size() < expected.size()) begin
            fail_run("Timeout while waiting for the status dump bytes");
        end
        repeat (40) @(negedge i_clock);  // any extra byte would show up here
        check(expected.size(), tx_bytes.size(), "dump byte count");
        foreach (expected[i]) begin
            check(expected[i], tx_bytes[i], $sformatf("dump byte %0d", i));
        end
        tx_bytes.delete();
    endtask

    task automatic send_info();
        i_pc_value = $urandom;
        send_byte(CMD_SEND_INFO);
        expect_dump();
    endtask

    task automatic load_image();
        byte_t image [IMEM_BYTES];
        int    n;
        writes.delete();
        send_byte(CMD_LOAD_IMEM);
        @(negedge i_clock);
        for (int i = 0; i < IMEM_BYTES; i++) begin
            image[i] = byte_t'($urandom);
            send_byte(image[i]);
            @(negedge i_clock);
        end
        for (n = 0; n < 100 && writes.size() < IMEM_BYTES; n++) begin
            @(negedge i_clock);
        end
        if (writes.size() < IMEM_BYTES) begin
            fail_run("Timeout while waiting for the instruction memory writes");
        end
        check(IMEM_BYTES, writes.size(), "imem write count");
        foreach (writes[i]) begin
            check(i, writes[i].addr, $sformatf("imem address of write %0d", i));
            check(image[i], writes[i].data, $sformatf("imem data of write %0d", i));
        end
    endtask

    // call right after the strobe that starts RUN
    task automatic run_until_halt();
        for (int n = 0; n < 20; n++) begin
            check(1, o_pipeline_enable, "pipeline enable in run");
            @(negedge i_clock);
        end
        i_pc_value = $urandom;
        i_halt     = 1'b1;
        check(1, o_pipeline_enable, "pipeline enable in the halt cycle");
        @(negedge i_clock);
        i_halt = 1'b0;
        check(0, o_pipeline_enable, "pipeline enable after halt");
        expect_dump();
    endtask

    task automatic run_to_halt();
        send_byte(CMD_CONTINUE);
        run_until_halt();
    endtask

    task automatic step_mode();
        send_byte(CMD_STEP_MODE);
        @(negedge i_clock);
        check(0, o_pipeline_enable, "pipeline enable in step mode");
        for (int s = 0; s < 2; s++) begin
            i_pc_value = $urandom;
            send_byte(CMD_STEP);
            check(1, o_pipeline_enable, "pipeline enable in the cycle after step");
            @(negedge i_clock);
            check(0, o_pipeline_enable, "pipeline enable after the step cycle");
            expect_dump();
        end
        send_byte(CMD_CONTINUE);
        run_until_halt();
    endtask

    initial begin
        void'($urandom(32'ha414e7f8));
        i_reset     = 1'b1;
        i_rx        = '0;
        i_halt      = 1'b0;
        i_tx_done   = 1'b0;
        i_pc_value  = '0;
        i_dmem_data = '0;
        i_reg_data  = '0;
        foreach (dmem[a]) begin
            dmem[a] = $urandom;
            regs[a] = $urandom;
        end
        foreach (tx_delay[k]) begin
            tx_delay[k] = $urandom_range(6, 1);
        end
        repeat (16) @(negedge i_clock);
        i_reset = 1'b0;

        reset_quiet();
        send_info();
        load_image();   // accepted only if the dump went back to idle
        run_to_halt();
        load_image();
        step_mode();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== bench/debug_unit_asserts.sv ====
`timescale 1ns/100ps

module debug_unit_asserts import debug_pkg::*; (
    input logic        i_clock,
    input logic        i_reset,
    input tx_byte_t    i_tx,
    input logic        i_tx_done,
    input imem_write_t i_imem,
    input dump_req_t   i_dmem_req,
    input dump_req_t   i_reg_req
);

    logic [IMEM_ADDR_W-1:0] last_write_addr;  // all ones so that a load begins at 0
    int unsigned            error_count = 0;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            last_write_addr <= '1;
        end else if (i_imem.write) begin
            last_write_addr <= i_imem.addr;
        end
    end

    tx_data_stable: assert property (@(posedge i_clock) disable iff (i_reset)
        i_tx.start && !i_tx_done |=> $stable(i_tx.data))
        else begin
            error_count++;
            $error("tx data changed before tx done");
        end

    tx_start_gap: assert property (@(posedge i_clock) disable iff (i_reset)
        i_tx_done |=> !i_tx.start)
        else begin
            error_count++;
            $error("tx start still high the cycle after tx done");
        end

    one_source_read: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_dmem_req.read && i_reg_req.read))
        else begin
            error_count++;
            $error("dmem and register reads high together");
        end

    imem_addr_step: assert property (@(posedge i_clock) disable iff (i_reset)
        i_imem.write |-> i_imem.addr == IMEM_ADDR_W'(last_write_addr + 1'b1))
        else begin
            error_count++;
            $error("imem write address out of sequence");
        end

endmodule

bind debug_unit debug_unit_asserts u_asserts (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_tx       (o_tx),
    .i_tx_done  (i_tx_done),
    .i_imem     (o_imem),
    .i_dmem_req (o_dmem_req),
    .i_reg_req  (o_reg_req)
);

// ==== hdl/debug_unit.sv ====
`timescale 1ns/100ps

module debug_unit import debug_pkg::*; (
    input  logic        i_clock,
    input  logic        i_reset,
    input  rx_byte_t    i_rx,
    input  logic        i_halt,
    input  logic        i_tx_done,
    input  word_t       i_pc_value,
    input  word_t       i_dmem_data,
    input  word_t       i_reg_data,
    output tx_byte_t    o_tx,
    output imem_write_t o_imem,
    output logic        o_pipeline_enable,
    output dump_req_t   o_dmem_req,
    output dump_req_t   o_reg_req
);

    logic [N_CHANNELS:0]   start_chain;  // done of channel i starts channel i+1
    logic [N_CHANNELS-1:0] chan_load;
    logic                  word_sent;
    word_t                 src_word  [N_CHANNELS];
    word_t                 chan_word [N_CHANNELS];
    dump_req_t             chan_req  [N_CHANNELS];

    assign src_word[CH_PC]   = i_pc_value;   // pc ignores the address
    assign src_word[CH_DMEM] = i_dmem_data;
    assign src_word[CH_REGS] = i_reg_data;

    command_decoder u_decoder (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx              (i_rx),
        .i_halt            (i_halt),
        .i_dump_done       (start_chain[N_CHANNELS]),
        .o_dump_start      (start_chain[0]),
        .o_pipeline_enable (o_pipeline_enable),
        .o_imem            (o_imem)
    );

    for (genvar g = 0; g < N_CHANNELS; g++) begin : g_channel
        dump_channel #(
            .WORDS (CHANNEL_WORDS[g])
        ) u_channel (
            .i_clock     (i_clock),
            .i_reset     (i_reset),
            .i_start     (start_chain[g]),
            .i_word      (src_word[g]),
            .i_word_sent (word_sent),
            .o_req       (chan_req[g]),
            .o_load      (chan_load[g]),
            .o_word      (chan_word[g]),
            .o_done      (start_chain[g+1])
        );
    end

    byte_serializer u_serializer (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_load      (chan_load),
        .i_word      (chan_word),
        .i_tx_done   (i_tx_done),
        .o_tx        (o_tx),
        .o_word_sent (word_sent)
    );

    assign o_dmem_req = chan_req[CH_DMEM];
    assign o_reg_req  = chan_req[CH_REGS];

endmodule

// ==== hdl/byte_serializer.sv ====
`timescale 1ns/100ps

module byte_serializer import debug_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic [N_CHANNELS-1:0] i_load,
    input  word_t                 i_word [N_CHANNELS],
    input  logic                  i_tx_done,
    output tx_byte_t              o_tx,
    output logic                  o_word_sent
);

    typedef enum logic [1:0] {
        IDLE,
        SEND,   // start high, waiting for tx done
        GAP     // start low between two bytes
    } state_t;

    state_t                state;
    logic [BYTE_CNT_W-1:0] byte_cnt;
    word_t                 shift_word;  // current byte sits on top
    word_t                 load_word;

    // only one channel is active, so at most one load bit is set
    always_comb begin
        load_word = i_word[0];
        for (int c = 0; c < N_CHANNELS; c++) begin
            if (i_load[c]) begin
                load_word = i_word[c];
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state       <= IDLE;
            byte_cnt    <= '0;
            o_word_sent <= 1'b0;
        end else begin
            o_word_sent <= 1'b0;

            case (state)
                IDLE: begin
                    if (|i_load) begin
                        byte_cnt <= '0;
                        state    <= SEND;
                    end
                end

                SEND: begin
                    if (i_tx_done) begin
                        if (byte_cnt == BYTE_CNT_W'(BYTES_PER_WORD - 1)) begin
                            o_word_sent <= 1'b1;
                            state       <= IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= GAP;
                        end
                    end
                end

                GAP: begin
                    state <= SEND;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == IDLE && |i_load) begin
            shift_word <= load_word;
        end else if (state == SEND && i_tx_done) begin
            shift_word <= shift_word << BYTE_W;  // msb first
        end
    end

    assign o_tx = '{start: (state == SEND), data: shift_word[WORD_W-1 -: BYTE_W]};

endmodule

// ==== hdl/dump_channel.sv ====
`timescale 1ns/100ps

module dump_channel import debug_pkg::*; #(
    parameter int WORDS = 32
) (
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      i_start,
    input  word_t     i_word,
    input  logic      i_word_sent,
    output dump_req_t o_req,
    output logic      o_load,
    output word_t     o_word,
    output logic      o_done
);

    typedef enum logic [1:0] {
        IDLE,
        READ,       // address on the bus, source samples it at the end
        CAPTURE,    // source data valid
        WAIT_SENT   // serializer busy with the word
    } state_t;

    state_t            state;
    logic [ADDR_W-1:0] addr;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state  <= IDLE;
            addr   <= '0;
            o_load <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_load <= 1'b0;
            o_done <= 1'b0;

            case (state)
                IDLE: begin
                    if (i_start) begin
                        addr  <= '0;
                        state <= READ;
                    end
                end

                READ: begin
                    state <= CAPTURE;
                end

                CAPTURE: begin
                    o_load <= 1'b1;
                    state  <= WAIT_SENT;
                end

                WAIT_SENT: begin
                    if (i_word_sent) begin
                        if (addr == ADDR_W'(WORDS - 1)) begin
                            o_done <= 1'b1;  // hands the turn to the next channel
                            state  <= IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= READ;
                        end
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == CAPTURE) begin
            o_word <= i_word;
        end
    end

    assign o_req = '{read: (state != IDLE), addr: addr};

endmodule

// ==== hdl/command_decoder.sv ====
`timescale 1ns/100ps

module command_decoder import debug_pkg::*; (
    input  logic        i_clock,
    input  logic        i_reset,
    input  rx_byte_t    i_rx,
    input  logic        i_halt,
    input  logic        i_dump_done,
    output logic        o_dump_start,
    output logic        o_pipeline_enable,
    output imem_write_t o_imem
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        READY,
        RUN,
        STEP,
        DUMP
    } state_t;

    state_t                 state;
    logic [IMEM_ADDR_W-1:0] load_count;    // next imem byte address
    logic                   back_to_step;  // where the dump returns
    logic                   imem_write;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    byte_t                  imem_data;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state             <= IDLE;
            load_count        <= '0;
            back_to_step      <= 1'b0;
            o_dump_start      <= 1'b0;
            o_pipeline_enable <= 1'b0;
            imem_write        <= 1'b0;
        end else begin
            o_dump_start <= 1'b0;
            imem_write   <= 1'b0;

            case (state)
                IDLE: begin
                    if (i_rx.done) begin
                        if (i_rx.data == CMD_LOAD_IMEM) begin
                            state      <= LOAD;
                            load_count <= '0;
                        end else if (i_rx.data == CMD_SEND_INFO) begin
                            state        <= DUMP;
                            back_to_step <= 1'b0;
                            o_dump_start <= 1'b1;
                        end
                    end
                end

                LOAD: begin
                    if (i_rx.done) begin
                        imem_write <= 1'b1;
                        load_count <= load_count + 1'b1;
                        if (load_count == IMEM_ADDR_W'(IMEM_BYTES - 1)) begin
                            state <= READY;  // last byte of the image
                        end
                    end
                end

                READY: begin
                    if (i_rx.done) begin
                        if (i_rx.data == CMD_STEP_MODE) begin
                            state <= STEP;
                        end else if (i_rx.data == CMD_CONTINUE) begin
                            state             <= RUN;
                            o_pipeline_enable <= 1'b1;
                        end
                    end
                end

                RUN: begin
                    if (i_halt) begin
                        state             <= DUMP;
                        back_to_step      <= 1'b0;
                        o_pipeline_enable <= 1'b0;
                        o_dump_start      <= 1'b1;
                    end
                end

                STEP: begin
                    if (i_halt) begin
                        state        <= DUMP;
                        back_to_step <= 1'b0;
                        o_dump_start <= 1'b1;
                    end else if (i_rx.done) begin
                        if (i_rx.data == CMD_STEP) begin
                            state             <= DUMP;
                            back_to_step      <= 1'b1;
                            o_pipeline_enable <= 1'b1;  // exactly one cycle
                        end else if (i_rx.data == CMD_CONTINUE) begin
                            state             <= RUN;
                            o_pipeline_enable <= 1'b1;
                        end
                    end
                end

                DUMP: begin
                    // a step runs its single enable cycle here, the dump starts after it
                    if (o_pipeline_enable) begin
                        o_pipeline_enable <= 1'b0;
                        o_dump_start      <= 1'b1;
                    end
                    if (i_halt) begin
                        back_to_step <= 1'b0;
                    end
                    if (i_dump_done) begin
                        state <= back_to_step ? STEP : IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == LOAD && i_rx.done) begin
            imem_addr <= load_count;
            imem_data <= i_rx.data;
        end
    end

    assign o_imem = '{write: imem_write, addr: imem_addr, data: imem_data};

endmodule

// ==== hdl/debug_pkg.sv ====
package debug_pkg;

    // sizes
    localparam int BYTE_W         = 8;
    localparam int WORD_W         = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_CNT_W     = $clog2(BYTES_PER_WORD);
    localparam int ADDR_W         = 5;     // data memory and register bank
    localparam int IMEM_ADDR_W    = 8;
    localparam int IMEM_BYTES     = 256;   // one full load

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [WORD_W-1:0] word_t;

    // command bytes, as typed on the host side
    localparam byte_t CMD_LOAD_IMEM = 8'h4c;   // 'L'
    localparam byte_t CMD_SEND_INFO = 8'h49;   // 'I'
    localparam byte_t CMD_STEP_MODE = 8'h53;   // 'S'
    localparam byte_t CMD_STEP      = 8'h4e;   // 'N'
    localparam byte_t CMD_CONTINUE  = 8'h43;   // 'C'

    // dump channels, sent in index order
    localparam int N_CHANNELS = 3;
    localparam int CH_PC      = 0;
    localparam int CH_DMEM    = 1;
    localparam int CH_REGS    = 2;

    localparam int CHANNEL_WORDS [N_CHANNELS] = '{1, 32, 32};

    // byte from the uart receiver
    typedef struct packed {
        logic  done;      // one cycle strobe
        byte_t data;
    } rx_byte_t;

    // byte to the uart transmitter
    typedef struct packed {
        logic  start;     // level, held until tx done
        byte_t data;
    } tx_byte_t;

    // instruction memory write port
    typedef struct packed {
        logic                   write;
        logic [IMEM_ADDR_W-1:0] addr;
        byte_t                  data;
    } imem_write_t;

    // read request to a word source, data comes back one cycle later
    typedef struct packed {
        logic              read;
        logic [ADDR_W-1:0] addr;
    } dump_req_t;

endpackage
